//--- project.f
+incdir+.
procPkg.sv
fetch.sv
decode.sv
control.sv
execute.sv
memory.sv
proc.sv
proc_sva.sv
procTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build outputs"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- procTb.sv
// Random programs checked against an instruction-level model of the core.
// Programs end in HALT or an illegal word, and branches only jump forward
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module procTb;
   import procPkg::*;

   localparam int MAX_PROG = 64;   // Program words indexed by pc[6:1]

   logic clk, rstN, run, progWrEn;
   logic [`DATA_W-1:0] progAddr, progData, dbgMemAddr, dbgRegData, dbgMemData;
   logic [2:0] dbgRegAddr;
   logic halted, err;

   logic [31:0] rngState;
   logic [15:0] prog [MAX_PROG];
   int progLen;
   logic [15:0] preVal [8];     // Register values after the prologue
   logic [15:0] mRegs [8];      // Model state
   logic [15:0] mMem [256];
   logic mValid [256];          // Word written in any test so far
   logic mTouched [256];        // Written by the current test
   logic mErr;
   int testCount, testFails, errCount;

   proc uut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // xorshift32
   function automatic logic [15:0] nextRand();
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState[15:0];
   endfunction

   function automatic logic [15:0] rFmt(functT f, logic [2:0] rs, logic [2:0] rt,
                                        logic [2:0] rd);
      return {RTYPE, rs, rt, rd, f};
   endfunction

   function automatic logic [15:0] iFmt(opcodeT op, logic [2:0] rs, logic [2:0] rd,
                                        logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] sext(logic [4:0] imm);
      return {{11{imm[4]}}, imm};
   endfunction

   // ISA arithmetic on rs and rt or the immediate
   function automatic logic [15:0] aluCalc(logic [1:0] sel, logic [15:0] a, logic [15:0] b);
      case (sel)
         2'd0:    return a + b;
         2'd1:    return a - b;
         2'd2:    return a ^ b;
         default: return a & ~b;
      endcase
   endfunction

   function automatic logic [15:0] randR();
      logic [15:0] r;
      r = nextRand();
      return rFmt(functT'(r[1:0]), r[4:2], r[7:5], r[10:8]);
   endfunction

   function automatic logic [15:0] randI();
      logic [15:0] r;
      r = nextRand();
      return iFmt(opcodeT'({3'b010, r[1:0]}), r[4:2], r[7:5], r[15:11]);   // Imm may be negative
   endfunction

   function automatic void emit(logic [15:0] w);
      prog[progLen] = w;
      progLen++;
   endfunction

   // Prologue clears then loads every register
   // zeroBias forces about a quarter of them to zero
   task automatic startProg(input logic zeroBias);
      logic [15:0] r;
      progLen = 0;
      for (int i = 0; i < 256; i++)
         mTouched[i] = 1'b0;
      for (int k = 0; k < 8; k++) begin
         r = nextRand();
         if (zeroBias && r[7:6] == 2'b00)
            r[4:0] = 5'd0;
         emit(iFmt(ANDNI, 3'(k), 3'(k), 5'h1f));   // x & ~0xffff gives 0
         emit(iFmt(ADDI, 3'(k), 3'(k), r[4:0]));
         preVal[k] = sext(r[4:0]);
      end
   endtask

   // Steps the program word by word until HALT or an illegal word
   task automatic runModel();
      instrT w;
      logic [15:0] pc;
      logic [15:0] a;
      logic [15:0] imm;
      logic [15:0] addr;
      logic done;
      pc = '0;
      done = 1'b0;
      mErr = 1'b0;
      for (int steps = 0; steps < 1000 && !done; steps++) begin
         w = prog[pc[6:1]];
         imm = sext(w.i.imm);
         a = mRegs[w.r.rs];
         addr = a + imm;
         pc = pc + 16'd2;
         case (w.r.opcode)
            HALT: done = 1'b1;
            NOP: ;
            RTYPE: mRegs[w.r.rd] = aluCalc(w.r.funct, a, mRegs[w.r.rt]);
            ADDI, SUBI, XORI, ANDNI: mRegs[w.i.rd] = aluCalc(w.i.opcode[1:0], a, imm);
            BEQZ: if (a == 16'h0) pc = pc + imm;
            BNEZ: if (a != 16'h0) pc = pc + imm;
            ST: begin
               mMem[addr[8:1]] = mRegs[w.i.rd];   // Data register in [7:5]
               mValid[addr[8:1]] = 1'b1;
               mTouched[addr[8:1]] = 1'b1;
            end
            LD: mRegs[w.i.rd] = mMem[addr[8:1]];
            default: begin
               mErr = 1'b1;
               done = 1'b1;
            end
         endcase
      end
   endtask

   // Bases r0..r3 stay fixed while loads go to r4..r7
   // Loads only read words already written
   task automatic genMemProg();
      logic gv [256];
      logic [15:0] r;
      logic [15:0] addr;
      logic [2:0] base;
      startProg(1'b0);
      for (int i = 0; i < 256; i++)
         gv[i] = mValid[i];
      for (int i = 0; i < 24; i++) begin
         r = nextRand();
         base = {1'b0, r[1:0]};
         addr = preVal[base] + sext(r[6:2]);
         if (r[15] && gv[addr[8:1]]) begin
            emit(iFmt(LD, base, {1'b1, r[8:7]}, r[6:2]));
         end else begin
            emit(iFmt(ST, base, r[11:9], r[6:2]));
            gv[addr[8:1]] = 1'b1;
         end
      end
      emit(iFmt(HALT, 3'd0, 3'd0, 5'd0));
   endtask

   // Forward branches that land inside the body or on the final HALT
   task automatic genBranchProg();
      logic [15:0] r;
      int skip;
      startProg(1'b1);
      for (int i = 0; i < 20; i++) begin
         r = nextRand();
         if (r[2:0] < 3'd3) begin
            skip = int'(r[5:3]);
            if (skip > 19 - i)
               skip = 19 - i;
            emit(iFmt(r[6] ? BEQZ : BNEZ, r[9:7], 3'd0, 5'(2 * skip)));
         end else begin
            emit(r[10] ? randR() : randI());
         end
      end
      emit(iFmt(HALT, 3'd0, 3'd0, 5'd0));
   endtask

   task automatic runTest(input string name);
      int cnt;
      int errsAtStart;
      errsAtStart = errCount;
      @(negedge clk);
      rstN = 1'b0;
      run = 1'b0;
      repeat (2) @(negedge clk);
      rstN = 1'b1;
      for (int i = 0; i < progLen; i++) begin   // One word per edge
         progWrEn = 1'b1;
         progAddr = 16'(2 * i);
         progData = prog[i];
         @(negedge clk);
      end
      progWrEn = 1'b0;
      runModel();
      run = 1'b1;
      cnt = 0;
      while (!halted && cnt < 2000) begin
         @(negedge clk);
         cnt++;
      end
      if (!halted) begin
         $display("timeout: halted never rose in test %s", name);
         $display("Result: FAILED");
         $finish;
      end
      repeat (4) begin   // Must stay stopped
         @(negedge clk);
         if (!halted) begin
            $display("halted dropped while run was high in test %s", name);
            errCount++;
         end
      end
      if (err !== mErr) begin
         $display("mismatch err: got %h expected %h", err, mErr);
         errCount++;
      end
      for (int i = 0; i < 8; i++) begin
         dbgRegAddr = 3'(i);
         @(negedge clk);
         if (dbgRegData !== mRegs[i]) begin
            $display("mismatch dbgRegData r%0d: got %h expected %h", i, dbgRegData, mRegs[i]);
            errCount++;
         end
      end
      for (int i = 0; i < 256; i++) begin
         if (mTouched[i]) begin
            dbgMemAddr = 16'(2 * i);
            @(negedge clk);
            if (dbgMemData !== mMem[i]) begin
               $display("mismatch dbgMemData @%h: got %h expected %h",
                        dbgMemAddr, dbgMemData, mMem[i]);
               errCount++;
            end
         end
      end
      @(negedge clk);
      run = 1'b0;
      testCount++;
      if (errCount == errsAtStart) begin
         $display("test %s: ok", name);
      end else begin
         testFails++;
         $display("test %s: %0d errors", name, errCount - errsAtStart);
      end
   endtask

   initial begin
      logic [15:0] word;
      rstN = 1'b0;
      run = 1'b0;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      dbgRegAddr = '0;
      dbgMemAddr = '0;
      rngState = 32'd42678;
      testCount = 0;
      testFails = 0;
      errCount = 0;
      for (int i = 0; i < 8; i++)
         mRegs[i] = '0;
      for (int i = 0; i < 256; i++) begin
         mMem[i] = '0;
         mValid[i] = 1'b0;
      end

      startProg(1'b0);
      repeat (20) emit(randR());
      emit(iFmt(HALT, 3'd0, 3'd0, 5'd0));
      runTest("rtype alu");

      startProg(1'b0);
      repeat (20) emit(randI());
      emit(iFmt(HALT, 3'd0, 3'd0, 5'd0));
      runTest("immediate alu");

      genMemProg();
      runTest("store load");

      genBranchProg();
      runTest("branches");

      startProg(1'b0);
      repeat (6) emit(randR());
      emit(iFmt(HALT, 3'd0, 3'd0, 5'd0));
      repeat (6) emit(randI());   // Never executed
      runTest("halt");

      startProg(1'b0);
      repeat (6) emit(randI());
      word = nextRand();
      emit({5'b11111, word[10:0]});   // Unused opcode
      repeat (4) emit(randR());
      runTest("illegal opcode");

      $display("tests %0d, failed %0d, errors %0d", testCount, testFails, errCount);
      if (errCount == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- proc_sva.sv
// Protocol checks on the core status and PC, bound into every proc instance.
// All properties are off while rstN is low
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module procSva (
   input logic               clk,
   input logic               rstN,
   input logic               run,
   input logic               halted,
   input logic               err,
   input logic               memEnable,
   input logic               memWr,
   input logic [`DATA_W-1:0] pc
);

   // Sticky until reset
   haltedHolds: assert property (@(posedge clk) disable iff (!rstN)
      halted |=> halted)
      else $error("halted fell without a reset");

   // PC frozen when not executing
   pcFrozen: assert property (@(posedge clk) disable iff (!rstN)
      (halted || !run) |=> $stable(pc))
      else $error("pc moved while halted or not running");

   errHalts: assert property (@(posedge clk) disable iff (!rstN)
      err |=> halted)
      else $error("err seen without halted on the next cycle");

   // Loading phase never touches data memory
   noStoreIdle: assert property (@(posedge clk) disable iff (!rstN)
      !run |-> !(memEnable && memWr))
      else $error("data memory write while run is low");

endmodule

bind proc procSva uSva (
   .clk(clk), .rstN(rstN), .run(run), .halted(halted), .err(err),
   .memEnable(memEnable), .memWr(memWr), .pc(pc)
);

`default_nettype wire

//--- proc.sv
// Single cycle core top. Load the program with run low, then raise run. Debug
// ports read registers and data memory at any time
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module proc (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         run,
   input  logic                         progWrEn,
   input  logic [`DATA_W-1:0]           progAddr,
   input  logic [`DATA_W-1:0]           progData,
   input  logic [$clog2(`NUM_REGS)-1:0] dbgRegAddr,
   output logic [`DATA_W-1:0]           dbgRegData,
   input  logic [`DATA_W-1:0]           dbgMemAddr,
   output logic [`DATA_W-1:0]           dbgMemData,
   output logic                         halted,
   output logic                         err
);
   import procPkg::*;

   instrT              instr;
   logic [`DATA_W-1:0] pc;
   logic [`DATA_W-1:0] rsVal, rtVal, immExt;
   logic [`DATA_W-1:0] aluOut, writeback;
   logic               zero;

   // Control outputs
   aluOpT aluOp;
   logic  regWrite, iFormat;             // Decode
   logic  aluSrcImm, passRs;             // Execute
   logic  memEnable, memWr, memToReg;    // Memory
   logic  pcBranch, halt;                // Fetch

   fetch uFetch (
      .clk(clk), .rstN(rstN), .run(run),
      .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
      .immExt(immExt), .pcBranch(pcBranch), .halt(halt),
      .instr(instr), .pc(pc), .halted(halted)
   );

   decode uDecode (
      .clk(clk), .rstN(rstN), .instr(instr),
      .regWrite(regWrite), .iFormat(iFormat), .writeback(writeback),
      .dbgRegAddr(dbgRegAddr),
      .rsVal(rsVal), .rtVal(rtVal), .immExt(immExt), .dbgRegData(dbgRegData)
   );

   control uControl (
      .instr(instr), .zero(zero), .run(run), .halted(halted),
      .regWrite(regWrite), .iFormat(iFormat), .aluOp(aluOp),
      .aluSrcImm(aluSrcImm), .passRs(passRs),
      .memEnable(memEnable), .memWr(memWr), .memToReg(memToReg),
      .pcBranch(pcBranch), .halt(halt), .err(err)
   );

   execute uExecute (
      .rsVal(rsVal), .rtVal(rtVal), .immExt(immExt),
      .aluOp(aluOp), .aluSrcImm(aluSrcImm), .passRs(passRs),
      .aluOut(aluOut), .zero(zero)
   );

   memory uMemory (
      .clk(clk), .aluOut(aluOut), .rtVal(rtVal),
      .memEnable(memEnable), .memWr(memWr), .memToReg(memToReg),
      .dbgMemAddr(dbgMemAddr),
      .writeback(writeback), .dbgMemData(dbgMemData)
   );

endmodule

`default_nettype wire

//--- memory.sv
// Data memory with combinational read and the writeback select. No reset on the
// array, and addresses wrap at the memory depth
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module memory (
   input  logic               clk,
   input  logic [`DATA_W-1:0] aluOut,      // Address or result
   input  logic [`DATA_W-1:0] rtVal,       // Store data
   input  logic               memEnable,
   input  logic               memWr,
   input  logic               memToReg,
   input  logic [`DATA_W-1:0] dbgMemAddr,  // Byte address
   output logic [`DATA_W-1:0] writeback,
   output logic [`DATA_W-1:0] dbgMemData
);
   localparam int DAW = $clog2(`DMEM_DEPTH);

   logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
   logic [`DATA_W-1:0] readData;

   always_ff @(posedge clk) begin
      if (memEnable && memWr)
         dmem[aluOut[DAW:1]] <= rtVal;   // Word addressed
   end

   assign readData = memEnable ? dmem[aluOut[DAW:1]] : '0;

   // Load data or ALU result back to the register file
   assign writeback = memToReg ? readData : aluOut;

   assign dbgMemData = dmem[dbgMemAddr[DAW:1]];

endmodule

`default_nettype wire

//--- execute.sv
// Two-operand ALU. Branches pass rs through so zero tests the register itself.
// No carry or overflow flags
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module execute (
   input  logic [`DATA_W-1:0] rsVal,
   input  logic [`DATA_W-1:0] rtVal,
   input  logic [`DATA_W-1:0] immExt,
   input  procPkg::aluOpT     aluOp,
   input  logic               aluSrcImm,
   input  logic               passRs,
   output logic [`DATA_W-1:0] aluOut,
   output logic               zero
);
   import procPkg::*;

   logic [`DATA_W-1:0] opB;
   logic [`DATA_W-1:0] result;

   assign opB = aluSrcImm ? immExt : rtVal;   // I format uses the immediate

   always_comb begin
      case (aluOp)
         ALU_ADD:  result = rsVal + opB;
         ALU_SUB:  result = rsVal - opB;   // rs minus operand
         ALU_XOR:  result = rsVal ^ opB;
         ALU_ANDN: result = rsVal & ~opB;
         default:  result = '0;
      endcase
   end

   assign aluOut = passRs ? rsVal : result;
   assign zero   = (aluOut == '0);   // Only consumed for branches

endmodule

`default_nettype wire

//--- control.sv
// Opcode decode for the single cycle core. All writes and branches are masked
// unless run is high and the core has not halted
`timescale 1ns/1ps
`default_nettype none

module control (
   input  procPkg::instrT instr,
   input  logic           zero,
   input  logic           run,
   input  logic           halted,
   output logic           regWrite,
   output logic           iFormat,
   output procPkg::aluOpT aluOp,
   output logic           aluSrcImm,
   output logic           passRs,
   output logic           memEnable,
   output logic           memWr,
   output logic           memToReg,
   output logic           pcBranch,
   output logic           halt,
   output logic           err
);
   import procPkg::*;

   logic active;
   logic regWriteRaw;
   logic memEnableRaw;
   logic memWrRaw;
   logic branchOp;
   logic branchIfZero;
   logic haltOp;
   logic illegal;

   assign active = run && !halted;

   always_comb begin
      // Defaults behave like NOP
      regWriteRaw  = 1'b0;
      iFormat      = 1'b0;
      aluOp        = ALU_ADD;
      aluSrcImm    = 1'b0;
      passRs       = 1'b0;
      memEnableRaw = 1'b0;
      memWrRaw     = 1'b0;
      memToReg     = 1'b0;
      branchOp     = 1'b0;
      branchIfZero = 1'b0;
      haltOp       = 1'b0;
      illegal      = 1'b0;

      case (instr.r.opcode)
         HALT: haltOp = 1'b1;
         NOP: ;
         RTYPE: begin
            regWriteRaw = 1'b1;
            case (instr.r.funct)
               ADD:     aluOp = ALU_ADD;
               SUB:     aluOp = ALU_SUB;
               XOR:     aluOp = ALU_XOR;
               ANDN:    aluOp = ALU_ANDN;
               default: illegal = 1'b1;   // Unknown funct
            endcase
         end
         ADDI, SUBI, XORI, ANDNI: begin
            regWriteRaw = 1'b1;
            iFormat     = 1'b1;
            aluSrcImm   = 1'b1;
            case (instr.i.opcode)   // Low opcode bits follow funct order
               SUBI:    aluOp = ALU_SUB;
               XORI:    aluOp = ALU_XOR;
               ANDNI:   aluOp = ALU_ANDN;
               default: aluOp = ALU_ADD;
            endcase
         end
         BEQZ, BNEZ: begin
            branchOp     = 1'b1;
            passRs       = 1'b1;   // Zero flag then reflects rs
            branchIfZero = (instr.r.opcode == BEQZ);
         end
         ST: begin
            aluSrcImm    = 1'b1;   // Address is rs + imm
            memEnableRaw = 1'b1;
            memWrRaw     = 1'b1;
         end
         LD: begin
            regWriteRaw  = 1'b1;
            iFormat      = 1'b1;
            aluSrcImm    = 1'b1;
            memEnableRaw = 1'b1;
            memToReg     = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

   // Side effects only while executing
   assign regWrite  = regWriteRaw && active;
   assign memEnable = memEnableRaw && active;
   assign memWr     = memWrRaw && active;
   assign pcBranch  = branchOp && active && (branchIfZero ? zero : !zero);

   assign err  = run && illegal;              // Stays up while PC sits on it
   assign halt = run && (haltOp || illegal);  // Latched by fetch

endmodule

`default_nettype wire

//--- decode.sv
// Register file and immediate extension. Registers have no reset, so their
// contents are undefined until written. Write enable comes pre-gated from control
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module decode (
   input  logic                        clk,
   input  logic                        rstN,
   input  procPkg::instrT              instr,
   input  logic                        regWrite,
   input  logic                        iFormat,
   input  logic [`DATA_W-1:0]          writeback,
   input  logic [$clog2(`NUM_REGS)-1:0] dbgRegAddr,
   output logic [`DATA_W-1:0]          rsVal,
   output logic [`DATA_W-1:0]          rtVal,
   output logic [`DATA_W-1:0]          immExt,
   output logic [`DATA_W-1:0]          dbgRegData
);
   import procPkg::*;

   localparam int RAW = $clog2(`NUM_REGS);
   localparam int IMM_W = 5;

   logic [`DATA_W-1:0] regs [`NUM_REGS];
   logic [RAW-1:0]     rsAddr;
   logic [RAW-1:0]     rtAddr;
   logic [RAW-1:0]     rdAddr;
   logic [IMM_W-1:0]   imm;

   // Source specifiers sit in the same bits for both formats
   assign rsAddr = instr.r.rs;
   assign rtAddr = instr.r.rt;
   assign imm    = instr.i.imm;

   // I format writes [7:5], R format writes [4:2]
   always_comb begin
      if (iFormat)
         rdAddr = instr.i.rd;
      else
         rdAddr = instr.r.rd;
   end

   // Write lands on the executing edge, held off during reset
   always_ff @(posedge clk) begin
      if (rstN && regWrite)
         regs[rdAddr] <= writeback;
   end

   // Async reads, no bypass needed in a single cycle core
   assign rsVal = regs[rsAddr];
   assign rtVal = regs[rtAddr];

   assign immExt = {{(`DATA_W-IMM_W){imm[IMM_W-1]}}, imm};   // Sign extend 5 bits

   assign dbgRegData = regs[dbgRegAddr];   // Debug peek

endmodule

`default_nettype wire

//--- fetch.sv
// PC and instruction memory. Program writes only land while run is low, and the
// PC freezes on a HALT or illegal word so it stays visible
`timescale 1ns/1ps
`default_nettype none
`include "proc_config.svh"

module fetch (
   input  logic              clk,
   input  logic              rstN,
   input  logic              run,
   input  logic              progWrEn,
   input  logic [`DATA_W-1:0] progAddr,   // Byte address
   input  logic [`DATA_W-1:0] progData,
   input  logic [`DATA_W-1:0] immExt,
   input  logic              pcBranch,
   input  logic              halt,
   output procPkg::instrT    instr,
   output logic [`DATA_W-1:0] pc,
   output logic              halted
);
   import procPkg::*;

   localparam int IAW = $clog2(`IMEM_DEPTH);

   logic [`DATA_W-1:0] imem [`IMEM_DEPTH];   // No reset, loaded by testbench
   logic [`DATA_W-1:0] pcPlus2;
   logic [`DATA_W-1:0] pcNext;

   // Program load port
   always_ff @(posedge clk) begin
      if (progWrEn && !run)
         imem[progAddr[IAW:1]] <= progData;
   end

   assign instr = imem[pc[IAW:1]];   // Combinational fetch

   assign pcPlus2 = pc + `DATA_W'd2;
   assign pcNext  = pcBranch ? pcPlus2 + immExt : pcPlus2;   // Offset from PC+2

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (run && !halted) begin
         if (halt)
            halted <= 1'b1;   // Sticky until reset, PC stays on the stop word
         else
            pc <= pcNext;
      end
   end

endmodule

`default_nettype wire

//--- procPkg.sv
// Opcode, funct and ALU encodings plus the two decodings of an instruction word.
// Field positions are fixed at a 16-bit instruction
`default_nettype none

package procPkg;

   // Primary opcode in bits [15:11], other codes are illegal
   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      ADDI  = 5'b01000,
      SUBI  = 5'b01001,
      XORI  = 5'b01010,
      ANDNI = 5'b01011,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      ST    = 5'b10000,
      LD    = 5'b10001,
      RTYPE = 5'b11011
   } opcodeT;

   typedef enum logic [1:0] {ADD, SUB, XOR, ANDN} functT;   // RTYPE only

   // Control to execute
   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN} aluOpT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      functT      funct;
   } rFormatT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [2:0] rd;   // Also the store data register
      logic [4:0] imm;  // Signed
   } iFormatT;

   // Same 16 bits, read as R or I format
   typedef union packed {
      rFormatT r;
      iFormatT i;
   } instrT;

endpackage

`default_nettype wire

//--- proc_config.svh
// Sizes shared by the core. Memories are word arrays, so depths are powers of two
// and addresses into them are byte addresses with bit 0 ignored
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Data path and instruction word width
`define DATA_W 16

// Register file entries, 3-bit specifiers in the encoding
`define NUM_REGS 8

// Instruction memory, in 16-bit words
`define IMEM_DEPTH 256

// Data memory, in 16-bit words
`define DMEM_DEPTH 256

`endif
